//--- Makefile
# Verilator simulation of the backplane command front end
# Override any variable on the command line, e.g. make sim LOG=run.log

VERILATOR ?= verilator
TOP       ?= bus_write_tb
FLIST     ?= flist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing

.PHONY: sim clean

# The run passes only if the log holds the pass line
sim:
	$(VERILATOR) $(VFLAGS) -f $(FLIST) --top-module $(TOP) --Mdir $(BUILD_DIR) -o $(TOP)
	$(BUILD_DIR)/$(TOP) | tee $(LOG)
	grep -qx "TB PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- bench/bus_write_tb.sv
`timescale 1ns/1ps

module bus_write_tb;

    //////////////////// Timing from the bus rules
    localparam int CLK_PERIOD_NS  = 100;
    localparam int DRIVE_DELAY_NS = 1;                // Inputs change after the edge
    localparam int RX_GAP_CYCLES  = 4;                // Spacing of rx strobes
    localparam int INIT_HOLD      = 100;              // Power-up hold in cycles
    localparam int UNIT_CYCLES    = 22;
    localparam int CARDS          = 4;
    localparam int PRE_UNITS      = 1;
    localparam int CARD_UNITS     = 4 + 1 + 2 + 2 + 1;   // Addr, data, low, high, release
    localparam int WR_LOW_MIN     = 2 * UNIT_CYCLES;
    localparam int MIN_LATENCY    = CARDS * CARD_UNITS * UNIT_CYCLES;
    localparam int REPLY_LEN      = 11;
    localparam int LINE_MAX       = 32;
    localparam int SETTLE_CYCLES  = 8;                // Reply done and back to idle
    localparam int SILENCE_CYCLES = (PRE_UNITS + CARDS * CARD_UNITS) * UNIT_CYCLES
                                    + 2 * REPLY_LEN + 128;
    localparam int ROW_BOUND      = SILENCE_CYCLES + SETTLE_CYCLES
                                    + (LINE_MAX + 1) * RX_GAP_CYCLES;
    localparam int NUM_TESTS      = 10;
    localparam int WATCHDOG_CYCLES = 2 * INIT_HOLD + NUM_TESTS * ROW_BOUND + 100;
    localparam logic [31:0] SEED  = 32'he5ac5989;
    localparam logic [7:0] LF_CHAR = 8'h0A;

    logic       clock;
    logic       rst_n;
    logic [7:0] rx_data;
    logic       rx_valid;
    logic [7:0] tx_data;
    logic       tx_valid;
    logic [7:0] bus_data;
    logic       bus_data_oe;
    logic [2:0] bus_addr;
    logic [3:0] card_sel;
    logic       test_addr;
    logic       rd_n;
    logic       wr_n;
    logic       lamp_reset;
    logic       level_oe;

    //////////////////// Test table
    string      row_name [NUM_TESTS];
    string      row_line [NUM_TESTS];
    bit         row_pass [NUM_TESTS];                 // Reply expected
    logic [2:0] row_addr [NUM_TESTS];
    logic [7:0] row_data [NUM_TESTS][CARDS];          // Data for card 0 to 3

    // Monitor records, cleared per row
    logic [3:0] sel_q[$];
    logic [2:0] addr_q[$];
    logic [7:0] data_q[$];
    logic       oe_q[$];
    int         low_q[$];                             // Low width of each strobe
    logic [7:0] tx_q[$];
    bit         back_to_back;
    time        first_tx_time;
    time        last_strobe_time;
    logic       prev_wr_n;
    logic       prev_tx_valid;
    int         low_run;

    int error_count;
    int tests_run;
    int tests_failed;

    tb_clock_gen #(.PERIOD_NS(CLK_PERIOD_NS), .RESET_CYCLES(4)) tb_clock_gen_inst (
        .clock (clock),
        .rst_n (rst_n)
    );

    bus_write_top bus_write_top_inst (
        .clock       (clock),
        .rst_n       (rst_n),
        .rx_data     (rx_data),
        .rx_valid    (rx_valid),
        .tx_data     (tx_data),
        .tx_valid    (tx_valid),
        .bus_data    (bus_data),
        .bus_data_oe (bus_data_oe),
        .bus_addr    (bus_addr),
        .card_sel    (card_sel),
        .test_addr   (test_addr),
        .rd_n        (rd_n),
        .wr_n        (wr_n),
        .lamp_reset  (lamp_reset),
        .level_oe    (level_oe)
    );

    task automatic check_value(input string test, input string what,
                               input logic [31:0] expected, input logic [31:0] actual);
        if (actual !== expected) begin
            $display("FAILED %s %s expected 0x%0h actual 0x%0h", test, what, expected, actual);
            error_count++;
        end
    endtask

    //////////////////// Bus and tx monitor
    // Sampled on the falling clock edge, away from DUT updates
    always @(negedge clock) begin
        if (rst_n) begin
            if (prev_wr_n && !wr_n) begin             // Falling edge of the strobe
                sel_q.push_back(card_sel);
                addr_q.push_back(bus_addr);
                data_q.push_back(bus_data);
                oe_q.push_back(bus_data_oe);
            end
            if (!wr_n) begin
                low_run++;
            end else if (!prev_wr_n) begin
                low_q.push_back(low_run);             // Strobe just released
                low_run = 0;
            end
            if (tx_valid) begin
                if (tx_q.size() == 0) first_tx_time = $time;
                if (prev_tx_valid) back_to_back = 1'b1;
                tx_q.push_back(tx_data);
            end
            prev_wr_n     = wr_n;
            prev_tx_valid = tx_valid;
        end
    end

    function automatic string hex_text(input logic [7:0] b, input bit upper);
        logic [3:0] nib [2];
        byte        ch [2];
        nib[0] = b[7:4];
        nib[1] = b[3:0];
        for (int i = 0; i < 2; i++) begin
            if (nib[i] < 4'd10) ch[i] = 8'h30 + nib[i];
            else ch[i] = (upper ? 8'h41 : 8'h61) + nib[i] - 8'd10;
        end
        return $sformatf("%c%c", ch[0], ch[1]);
    endfunction

    function automatic void set_row(input int i, input string name, input string line,
                                    input bit pass, input logic [7:0] b0,
                                    input logic [7:0] d0, input logic [7:0] d1,
                                    input logic [7:0] d2, input logic [7:0] d3);
        row_name[i]    = name;
        row_line[i]    = line;
        row_pass[i]    = pass;
        row_addr[i]    = b0[2:0];                     // Only the low 3 bits reach the bus
        row_data[i][0] = d0;
        row_data[i][1] = d1;
        row_data[i][2] = d2;
        row_data[i][3] = d3;
    endfunction

    function automatic void fill_table();
        logic [7:0] rb [5];
        string      txt;
        set_row(0, "valid_upper", "pb_i_write,05A1B2C3D4", 1, 8'h05, 8'hA1, 8'hB2, 8'hC3, 8'hD4);
        set_row(1, "valid_lower", "pb_i_write,05a1b2c3d4", 1, 8'h05, 8'hA1, 8'hB2, 8'hC3, 8'hD4);
        set_row(2, "read_cmd", "pb_i_read,0512345678", 0, 8'h00, 8'h00, 8'h00, 8'h00, 8'h00);
        set_row(3, "unknown_word", "pb_x_write,0011223344", 0, 8'h00, 8'h00, 8'h00, 8'h00, 8'h00);
        set_row(4, "short_line", "pb_i_write,01234", 0, 8'h00, 8'h00, 8'h00, 8'h00, 8'h00);
        set_row(5, "after_reject", "pb_i_write,3F00FF7E81", 1, 8'h3F, 8'h00, 8'hFF, 8'h7E, 8'h81);
        set_row(6, "non_hex", "pb_i_write,0GZ1x2Q3--", 1, 8'h0F, 8'hF1, 8'hF2, 8'hF3, 8'hFF);
        set_row(7, "mixed_case", "pb_i_write,02aBcDeFaf", 1, 8'h02, 8'hAB, 8'hCD, 8'hEF, 8'hAF);
        for (int r = 0; r < 2; r++) begin
            txt = "pb_i_write,";
            for (int j = 0; j < 5; j++) begin
                rb[j] = 8'($urandom);
                txt = {txt, hex_text(rb[j], r == 0)};   // Row 8 upper case, row 9 lower
            end
            set_row(8 + r, (r == 0) ? "random_upper" : "random_lower", txt, 1,
                    rb[0], rb[1], rb[2], rb[3], rb[4]);
        end
    endfunction

    // Reply text "Pass 0x56" then CR and LF
    function automatic logic [7:0] reply_char(input int i);
        string text;
        text = "Pass 0x56";
        if (i < 9) return text[i];
        if (i == 9) return 8'h0D;
        return 8'h0A;
    endfunction

    task automatic send_byte(input logic [7:0] c);
        @(posedge clock);
        #(DRIVE_DELAY_NS);
        rx_data          = c;
        rx_valid         = 1'b1;
        last_strobe_time = $time;
        @(posedge clock);
        #(DRIVE_DELAY_NS);
        rx_valid = 1'b0;                              // One-cycle strobe
        repeat (RX_GAP_CYCLES - 2) @(posedge clock);
    endtask

    task automatic finish_test(input string name, input int errs_before);
        tests_run++;
        if (error_count == errs_before) begin
            $display("test %-14s ok", name);
        end else begin
            $display("test %-14s %0d failed checks", name, error_count - errs_before);
            tests_failed++;
        end
    endtask

    task automatic check_power_up();
        int hold;
        int errs_before;
        hold        = 0;
        errs_before = error_count;
        @(posedge rst_n);
        while (lamp_reset === 1'b1 && hold < 2 * INIT_HOLD) begin
            @(posedge clock);
            hold++;
            @(negedge clock);
            if (lamp_reset === 1'b1) begin            // Still inside the hold
                check_value("power_up", "level_oe", 0, level_oe);
                check_value("power_up", "bus_data_oe", 0, bus_data_oe);
                check_value("power_up", "wr_n", 1, wr_n);
                check_value("power_up", "rd_n", 1, rd_n);
                check_value("power_up", "test_addr", 1, test_addr);
                check_value("power_up", "card_sel", 0, card_sel);
                check_value("power_up", "tx_valid", 0, tx_valid);
            end
        end
        check_value("power_up", "hold cycles", INIT_HOLD, hold);
        check_value("power_up", "lamp_reset", 0, lamp_reset);
        check_value("power_up", "level_oe", 1, level_oe);
        finish_test("power_up", errs_before);
    endtask

    task automatic run_row(input int t);
        int  errs_before;
        int  waited;
        time latency;
        errs_before = error_count;
        sel_q.delete();
        addr_q.delete();
        data_q.delete();
        oe_q.delete();
        low_q.delete();
        tx_q.delete();
        back_to_back = 1'b0;
        for (int i = 0; i < row_line[t].len(); i++) send_byte(row_line[t][i]);
        send_byte(LF_CHAR);
        if (row_pass[t]) begin
            waited = 0;
            while (tx_q.size() < REPLY_LEN && waited < SILENCE_CYCLES) begin
                @(posedge clock);
                waited++;
            end
            repeat (SETTLE_CYCLES) @(posedge clock);
            if (tx_q.size() != REPLY_LEN) begin
                $display("%s: reply has %0d bytes instead of %0d", row_name[t],
                         tx_q.size(), REPLY_LEN);
                error_count++;
            end
            check_value(row_name[t], "write strobes", CARDS, sel_q.size());
            for (int k = 0; k < CARDS && k < sel_q.size(); k++) begin
                check_value(row_name[t], $sformatf("card_sel %0d", k), 4'b0001 << k, sel_q[k]);
                check_value(row_name[t], $sformatf("bus_addr %0d", k), row_addr[t], addr_q[k]);
                check_value(row_name[t], $sformatf("bus_data %0d", k), row_data[t][k], data_q[k]);
                check_value(row_name[t], $sformatf("bus_data_oe %0d", k), 1, oe_q[k]);
                if (k < low_q.size() && low_q[k] < WR_LOW_MIN) begin
                    $display("%s: wr_n low for only %0d cycles on card %0d", row_name[t],
                             low_q[k], k);
                    error_count++;
                end
            end
            for (int i = 0; i < REPLY_LEN && i < tx_q.size(); i++) begin
                check_value(row_name[t], $sformatf("reply byte %0d", i), reply_char(i), tx_q[i]);
            end
            if (back_to_back) begin
                $display("%s: tx_valid was high on consecutive cycles", row_name[t]);
                error_count++;
            end
            latency = (first_tx_time - last_strobe_time) / CLK_PERIOD_NS;
            if (tx_q.size() > 0 && latency < MIN_LATENCY) begin
                $display("%s: reply came after %0d cycles, too early", row_name[t], latency);
                error_count++;
            end
        end else begin
            repeat (SILENCE_CYCLES) @(posedge clock);   // Nothing may happen here
            check_value(row_name[t], "write strobes", 0, sel_q.size());
            check_value(row_name[t], "reply bytes", 0, tx_q.size());
        end
        finish_test(row_name[t], errs_before);
    endtask

    //////////////////// Watchdog
    initial begin
        #(longint'(WATCHDOG_CYCLES) * CLK_PERIOD_NS);
        $display("watchdog expired after %0d cycles, run did not finish", WATCHDOG_CYCLES);
        $display("TB FAILED");
        $finish;
    end

    //////////////////// Main sequence
    initial begin
        rx_data       = 8'h00;
        rx_valid      = 1'b0;
        prev_wr_n     = 1'b1;
        prev_tx_valid = 1'b0;
        low_run       = 0;
        back_to_back  = 1'b0;
        first_tx_time = 0;
        last_strobe_time = 0;
        error_count   = 0;
        tests_run     = 0;
        tests_failed  = 0;
        void'($urandom(SEED));                        // Seeds this process once
        fill_table();
        check_power_up();
        for (int t = 0; t < NUM_TESTS; t++) run_row(t);
        $display("tests run %0d, tests failed %0d, failed checks %0d",
                 tests_run, tests_failed, error_count);
        if (error_count == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

//--- bench/tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen #(
    parameter int PERIOD_NS    = 100,
    parameter int RESET_CYCLES = 4
) (
    output logic clock,
    output logic rst_n
);

    initial begin
        clock = 1'b0;
        forever #(PERIOD_NS / 2) clock = ~clock;      // Free-running
    end

    initial begin
        rst_n = 1'b0;                                 // Asserted from time zero
        repeat (RESET_CYCLES) @(posedge clock);
        #1 rst_n = 1'b1;                              // Release just after an edge
    end

endmodule

//--- flist.f
verilog/bus_cmd_pkg.sv
verilog/cmd_receiver.sv
verilog/param_decoder.sv
verilog/cmd_sequencer.sv
verilog/card_write_engine.sv
verilog/reply_sender.sv
verilog/bus_write_top.sv
bench/tb_clock_gen.sv
bench/bus_write_tb.sv

//--- verilog/bus_cmd_pkg.sv
package bus_cmd_pkg;

    //////////////////// Widths and types
    typedef logic [7:0] byte_t;                      // One character or data byte

    localparam int LINE_BYTES = 32;                  // Line buffer depth
    typedef logic [LINE_BYTES*8-1:0] line_t;         // Byte 0 in bits 7:0, first received
    typedef logic [5:0] line_len_t;                  // Characters stored in a line

    localparam int CMD_CHARS = 11;                   // Command word with comma
    localparam logic [CMD_CHARS*8-1:0] CMD_WRITE = "pb_i_write,";
    localparam int PARAM_BYTES = 5;                  // From 10 hex characters
    localparam int MIN_LINE_CHARS = 21;              // Command word plus hex field
    typedef logic [PARAM_BYTES*8-1:0] params_t;      // Byte 0 in bits 7:0

    localparam int CARD_COUNT = 4;
    typedef logic [CARD_COUNT-1:0] card_sel_t;       // One-hot card select
    typedef logic [2:0] bus_addr_t;

    //////////////////// Bus timing
    localparam int WAIT_UNIT_CYCLES = 22;            // Cycles in one wait unit
    typedef logic [4:0] cyc_cnt_t;                   // Counts cycles inside a unit
    typedef logic [2:0] wait_units_t;                // Counts remaining units
    localparam wait_units_t PRE_UNITS     = 3'd1;    // Before the first card
    localparam wait_units_t ADDR_UNITS    = 3'd4;    // Address and select settle
    localparam wait_units_t DATA_UNITS    = 3'd1;    // Data setup
    localparam wait_units_t WR_LOW_UNITS  = 3'd2;    // Strobe low width
    localparam wait_units_t WR_HIGH_UNITS = 3'd2;    // Data hold after strobe
    localparam wait_units_t RELEASE_UNITS = 3'd1;    // Bus turnaround

    localparam int INIT_CYCLES = 100;                // Power-up hold length
    typedef logic [6:0] init_cnt_t;

    //////////////////// Reply text
    localparam byte_t LF = 8'h0A;
    localparam byte_t CR = 8'h0D;
    localparam byte_t PASS_CODE = 8'h56;
    localparam logic [7*8-1:0] PASS_TEXT = "Pass 0x";    // First character in MSB
    localparam int REPLY_CHARS = 11;                 // Text, two hex digits, CR, LF
    typedef logic [3:0] reply_idx_t;

    typedef enum logic [2:0] {
        INIT,                                        // Power-up hold
        IDLE,                                        // Gathering a line
        DECODE,                                      // Checking the command word
        WRITE,                                       // Four-card bus write
        REPLY                                        // Sending the pass text
    } seq_state_t;

    // Digits and both letter cases, anything else reads as F
    function automatic logic [3:0] hex_char_to_nibble(input byte_t c);
        if (c >= "0" && c <= "9") return c[3:0];
        if ((c >= "a" && c <= "f") || (c >= "A" && c <= "F")) return c[3:0] + 4'd9;
        return 4'hF;
    endfunction

    function automatic byte_t nibble_to_hex_char(input logic [3:0] n);
        return (n < 4'd10) ? (8'h30 + {4'h0, n}) : (8'h37 + {4'h0, n});    // Upper case
    endfunction

endpackage

//--- verilog/bus_write_top.sv
`timescale 1ns/1ps

module bus_write_top (
    input  logic                   clock,
    input  logic                   rst_n,
    input  bus_cmd_pkg::byte_t     rx_data,
    input  logic                   rx_valid,
    output bus_cmd_pkg::byte_t     tx_data,
    output logic                   tx_valid,
    output bus_cmd_pkg::byte_t     bus_data,
    output logic                   bus_data_oe,
    output bus_cmd_pkg::bus_addr_t bus_addr,
    output bus_cmd_pkg::card_sel_t card_sel,
    output logic                   test_addr,
    output logic                   rd_n,
    output logic                   wr_n,
    output logic                   lamp_reset,
    output logic                   level_oe
);
    import bus_cmd_pkg::*;

    //////////////////// Internal links
    logic      rx_enable;
    line_t     line_buf;
    line_len_t line_len;
    logic      line_done;
    logic      cmd_ok;
    params_t   params;
    logic      write_start;
    logic      write_done;
    logic      reply_start;
    logic      reply_done;

    cmd_receiver cmd_receiver_inst (
        .clock     (clock),
        .rst_n     (rst_n),
        .rx_data   (rx_data),
        .rx_valid  (rx_valid),
        .rx_enable (rx_enable),
        .line_buf  (line_buf),
        .line_len  (line_len),
        .line_done (line_done)
    );

    param_decoder param_decoder_inst (
        .line_buf (line_buf),
        .line_len (line_len),
        .cmd_ok   (cmd_ok),
        .params   (params)
    );

    cmd_sequencer cmd_sequencer_inst (
        .clock       (clock),
        .rst_n       (rst_n),
        .line_done   (line_done),
        .cmd_ok      (cmd_ok),
        .write_done  (write_done),
        .reply_done  (reply_done),
        .rx_enable   (rx_enable),
        .write_start (write_start),
        .reply_start (reply_start),
        .lamp_reset  (lamp_reset),
        .level_oe    (level_oe)
    );

    card_write_engine card_write_engine_inst (
        .clock       (clock),
        .rst_n       (rst_n),
        .write_start (write_start),
        .params      (params),
        .bus_data    (bus_data),
        .bus_data_oe (bus_data_oe),
        .bus_addr    (bus_addr),
        .card_sel    (card_sel),
        .test_addr   (test_addr),
        .rd_n        (rd_n),
        .wr_n        (wr_n),
        .write_done  (write_done)
    );

    reply_sender reply_sender_inst (
        .clock       (clock),
        .rst_n       (rst_n),
        .reply_start (reply_start),
        .tx_data     (tx_data),
        .tx_valid    (tx_valid),
        .reply_done  (reply_done)
    );

endmodule

//--- verilog/card_write_engine.sv
`timescale 1ns/1ps

module card_write_engine (
    input  logic                   clock,
    input  logic                   rst_n,
    input  logic                   write_start,
    input  bus_cmd_pkg::params_t   params,
    output bus_cmd_pkg::byte_t     bus_data,
    output logic                   bus_data_oe,
    output bus_cmd_pkg::bus_addr_t bus_addr,
    output bus_cmd_pkg::card_sel_t card_sel,
    output logic                   test_addr,
    output logic                   rd_n,
    output logic                   wr_n,
    output logic                   write_done
);
    import bus_cmd_pkg::*;

    typedef enum logic [2:0] {
        ENG_IDLE,
        ENG_ADDR,                                     // Select card, drive address
        ENG_DATA,                                     // Drive data byte
        ENG_WR_LOW,                                   // Strobe low
        ENG_WR_HIGH,                                  // Strobe released
        ENG_RELEASE,                                  // Data driver off
        ENG_WAIT,                                     // Wait-unit timer
        ENG_NEXT                                      // Advance to next card
    } step_t;

    step_t       step;
    step_t       ret_step;                            // Step after the wait
    logic [$clog2(CARD_COUNT)-1:0] card_idx;
    cyc_cnt_t    cyc_cnt;
    wait_units_t unit_cnt;

    wire [2:0] data_sel = {1'b0, card_idx} + 3'd1;   // Byte 0 is the address

    assign test_addr = 1'b1;                          // Never used for writes

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            step        <= ENG_IDLE;
            ret_step    <= ENG_IDLE;
            card_idx    <= '0;
            cyc_cnt     <= '0;
            unit_cnt    <= '0;
            bus_data    <= '0;
            bus_data_oe <= 1'b0;
            bus_addr    <= '0;
            card_sel    <= '0;
            rd_n        <= 1'b1;
            wr_n        <= 1'b1;
            write_done  <= 1'b0;
        end else begin
            write_done <= 1'b0;
            case (step)
                ENG_IDLE: begin
                    if (write_start) begin
                        card_idx <= '0;
                        unit_cnt <= PRE_UNITS;        // Lead-in before card 0
                        ret_step <= ENG_ADDR;
                        step     <= ENG_WAIT;
                    end
                end
                ENG_ADDR: begin
                    card_sel <= card_sel_t'(1) << card_idx;
                    bus_addr <= params[2:0];          // Low 3 bits of byte 0
                    wr_n     <= 1'b1;
                    rd_n     <= 1'b1;
                    unit_cnt <= ADDR_UNITS;
                    ret_step <= ENG_DATA;
                    step     <= ENG_WAIT;
                end
                ENG_DATA: begin
                    bus_data    <= params[data_sel*8 +: 8];
                    bus_data_oe <= 1'b1;
                    unit_cnt    <= DATA_UNITS;
                    ret_step    <= ENG_WR_LOW;
                    step        <= ENG_WAIT;
                end
                ENG_WR_LOW: begin
                    wr_n     <= 1'b0;                 // Active low strobe
                    unit_cnt <= WR_LOW_UNITS;
                    ret_step <= ENG_WR_HIGH;
                    step     <= ENG_WAIT;
                end
                ENG_WR_HIGH: begin
                    wr_n     <= 1'b1;                 // Card latches on this edge
                    unit_cnt <= WR_HIGH_UNITS;
                    ret_step <= ENG_RELEASE;
                    step     <= ENG_WAIT;
                end
                ENG_RELEASE: begin
                    bus_data_oe <= 1'b0;
                    unit_cnt    <= RELEASE_UNITS;
                    ret_step    <= ENG_NEXT;
                    step        <= ENG_WAIT;
                end
                ENG_WAIT: begin
                    // N units take N*WAIT_UNIT_CYCLES, one more to leave
                    if (unit_cnt != '0) begin
                        if (cyc_cnt == cyc_cnt_t'(WAIT_UNIT_CYCLES - 1)) begin
                            cyc_cnt  <= '0;
                            unit_cnt <= unit_cnt - 1'b1;
                        end else begin
                            cyc_cnt <= cyc_cnt + 1'b1;
                        end
                    end else begin
                        step <= ret_step;
                    end
                end
                ENG_NEXT: begin
                    if (card_idx == CARD_COUNT - 1) begin
                        write_done <= 1'b1;           // All cards written
                        step       <= ENG_IDLE;
                    end else begin
                        card_idx <= card_idx + 1'b1;
                        step     <= ENG_ADDR;
                    end
                end
                default: step <= ENG_IDLE;
            endcase
        end
    end

endmodule

//--- verilog/cmd_receiver.sv
`timescale 1ns/1ps

module cmd_receiver (
    input  logic                  clock,
    input  logic                  rst_n,
    input  bus_cmd_pkg::byte_t    rx_data,
    input  logic                  rx_valid,
    input  logic                  rx_enable,          // High only while the sequencer idles
    output bus_cmd_pkg::line_t    line_buf,
    output bus_cmd_pkg::line_len_t line_len,
    output logic                  line_done
);
    import bus_cmd_pkg::*;

    line_len_t wr_idx;                                // Next free buffer slot

    wire take_byte = rx_valid && rx_enable;          // Strobes outside IDLE are dropped
    wire is_lf     = (rx_data == LF);

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            wr_idx    <= '0;
            line_len  <= '0;
            line_done <= 1'b0;
        end else begin
            line_done <= 1'b0;                        // Pulse
            if (take_byte && is_lf) begin
                line_len  <= wr_idx;                  // Length without the LF
                line_done <= 1'b1;
                wr_idx    <= '0;                      // Next line starts at slot 0
            end else if (take_byte && wr_idx < line_len_t'(LINE_BYTES)) begin
                wr_idx <= wr_idx + 1'b1;
            end
        end
    end

    // Character storage
    always_ff @(posedge clock) begin
        if (take_byte && !is_lf && wr_idx < line_len_t'(LINE_BYTES)) begin
            line_buf[wr_idx*8 +: 8] <= rx_data;
        end
    end

endmodule

//--- verilog/cmd_sequencer.sv
`timescale 1ns/1ps

module cmd_sequencer (
    input  logic clock,
    input  logic rst_n,
    input  logic line_done,                           // Line complete from receiver
    input  logic cmd_ok,                              // Decoder verdict
    input  logic write_done,
    input  logic reply_done,
    output logic rx_enable,
    output logic write_start,
    output logic reply_start,
    output logic lamp_reset,
    output logic level_oe
);
    import bus_cmd_pkg::*;

    seq_state_t state;
    init_cnt_t  init_cnt;                             // Power-up hold counter

    assign rx_enable = (state == IDLE);

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            state       <= INIT;
            init_cnt    <= '0;
            write_start <= 1'b0;
            reply_start <= 1'b0;
            lamp_reset  <= 1'b1;                      // Lamps held in reset
            level_oe    <= 1'b0;                      // Level shifter off
        end else begin
            write_start <= 1'b0;
            reply_start <= 1'b0;
            case (state)
                INIT: begin
                    if (init_cnt == init_cnt_t'(INIT_CYCLES - 1)) begin
                        lamp_reset <= 1'b0;           // Release lamps and
                        level_oe   <= 1'b1;           // enable shifter together
                        state      <= IDLE;
                    end else begin
                        init_cnt <= init_cnt + 1'b1;
                    end
                end
                IDLE: begin
                    if (line_done) state <= DECODE;
                end
                DECODE: begin
                    if (cmd_ok) begin
                        write_start <= 1'b1;
                        state       <= WRITE;
                    end else begin
                        state <= IDLE;                // Failure sends nothing
                    end
                end
                WRITE: begin
                    if (write_done) begin
                        reply_start <= 1'b1;
                        state       <= REPLY;
                    end
                end
                REPLY: begin
                    if (reply_done) state <= IDLE;
                end
                default: state <= IDLE;
            endcase
        end
    end

endmodule

//--- verilog/param_decoder.sv
`timescale 1ns/1ps

module param_decoder (
    input  bus_cmd_pkg::line_t     line_buf,
    input  bus_cmd_pkg::line_len_t line_len,
    output logic                   cmd_ok,
    output bus_cmd_pkg::params_t   params
);
    import bus_cmd_pkg::*;

    logic [CMD_CHARS*8-1:0] cmd_word;                 // First character in MSB, like CMD_WRITE

    always_comb begin
        for (int i = 0; i < CMD_CHARS; i++) begin
            cmd_word[(CMD_CHARS-1-i)*8 +: 8] = line_buf[i*8 +: 8];
        end
    end

    // Word must match and the full hex field must be present
    assign cmd_ok = (cmd_word == CMD_WRITE) && (line_len >= line_len_t'(MIN_LINE_CHARS));

    //////////////////// Hex field
    // Comma always sits at CMD_CHARS-1, so pairs start right after it
    always_comb begin
        for (int i = 0; i < PARAM_BYTES; i++) begin
            params[i*8+4 +: 4] = hex_char_to_nibble(line_buf[(CMD_CHARS+2*i)*8 +: 8]);
            params[i*8 +: 4]   = hex_char_to_nibble(line_buf[(CMD_CHARS+2*i+1)*8 +: 8]);
        end
    end

endmodule

//--- verilog/reply_sender.sv
`timescale 1ns/1ps

module reply_sender (
    input  logic               clock,
    input  logic               rst_n,
    input  logic               reply_start,
    output bus_cmd_pkg::byte_t tx_data,
    output logic               tx_valid,
    output logic               reply_done
);
    import bus_cmd_pkg::*;

    reply_idx_t idx;                                  // Next character position
    logic       active;
    logic       pace;                                 // Idle phase between strobes
    byte_t      next_char;

    // Character at the current position
    always_comb begin
        if (idx < reply_idx_t'(7)) begin
            next_char = PASS_TEXT[(6 - idx)*8 +: 8];
        end else begin
            case (idx)
                4'd7:    next_char = nibble_to_hex_char(PASS_CODE[7:4]);
                4'd8:    next_char = nibble_to_hex_char(PASS_CODE[3:0]);
                4'd9:    next_char = CR;
                default: next_char = LF;
            endcase
        end
    end

    wire send_now = active && !pace && (idx != reply_idx_t'(REPLY_CHARS));

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            idx        <= '0;
            active     <= 1'b0;
            pace       <= 1'b0;
            tx_valid   <= 1'b0;
            reply_done <= 1'b0;
        end else begin
            tx_valid   <= 1'b0;
            reply_done <= 1'b0;
            if (reply_start) begin
                idx    <= '0;
                active <= 1'b1;
                pace   <= 1'b0;
            end else if (active) begin
                pace <= !pace;
                if (send_now) begin
                    tx_valid <= 1'b1;
                end else if (pace) begin
                    idx <= idx + 1'b1;
                end else begin
                    reply_done <= 1'b1;               // Slot after the LF
                    active     <= 1'b0;
                end
            end
        end
    end

    always_ff @(posedge clock) begin
        if (send_now) tx_data <= next_char;
    end

endmodule
